//--- design/mmem_pkg.sv
// **********************************************************
// M-memory geometry: word count, address and word types
// shared by the RAM, its port interface and the front end.
// **********************************************************

package mmem_pkg;

   // Word address width.
   localparam int ADDR_W = 5;

   // Word width.
   localparam int DATA_W = 32;

   // Number of words.
   localparam int DEPTH = 32;

   // One scratchpad word.
   typedef logic [DATA_W-1:0] word_t;

   // One word address.
   typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- design/axil_pkg.sv
// **********************************************************
// AXI4-Lite host bus: widths, response codes and the
// payloads carried on the B and R channels.
// **********************************************************

package axil_pkg;

   localparam int AXI_ADDR_W = 8;                 // Byte address on the bus.
   localparam int STRB_W     = 4;                 // One strobe per byte lane.

   // Last byte address that maps to a word.
   localparam logic [AXI_ADDR_W-1:0] MAX_BYTE_ADDR = 8'h7C;

   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // Write response.
   typedef struct packed {
      resp_t resp;
   } b_payload_t;

   // Read response.
   typedef struct packed {
      mmem_pkg::word_t data;
      resp_t           resp;
   } r_payload_t;

endpackage

//--- design/mem_port_if.sv
// **********************************************************
// One RAM port: address, write data, enables, read data.
// **********************************************************

`timescale 1ns/100ps

interface mem_port_if;

   mmem_pkg::addr_t address;
   mmem_pkg::word_t data;
   logic            wren;                         // One-cycle write pulse.
   logic            rden;                         // One-cycle read pulse.
   mmem_pkg::word_t q;                            // Valid the cycle after rden.

   modport requester
   (
      output address,
      output data,
      output wren,
      output rden,
      input  q
   );

   modport memory
   (
      input  address,
      input  data,
      input  wren,
      input  rden,
      output q
   );

endinterface

//--- design/axil_mmem_front.sv
// **********************************************************
// AXI4-Lite slave for the host side of the M-memory. Checks
// each request, drives RAM port A and loads the responses.
// **********************************************************

`timescale 1ns/100ps

module axil_mmem_front
(
   input  logic                              clk_a,
   input  logic                              reset,
   input  logic [axil_pkg::AXI_ADDR_W-1:0]   awaddr,
   input  logic                              awvalid,
   output logic                              awready,
   input  mmem_pkg::word_t                   wdata,
   input  logic [axil_pkg::STRB_W-1:0]       wstrb,
   input  logic                              wvalid,
   output logic                              wready,
   input  logic [axil_pkg::AXI_ADDR_W-1:0]   araddr,
   input  logic                              arvalid,
   output logic                              arready,
   output logic                              b_valid,
   output axil_pkg::b_payload_t              b_payload,
   input  logic                              b_in_ready,
   output logic                              r_valid,
   output axil_pkg::r_payload_t              r_payload,
   input  logic                              r_in_ready,
   mem_port_if.requester                     mem
);

   typedef enum logic [2:0]
   {
      ST_IDLE,
      ST_WRITE,
      ST_RD_ISSUE,
      ST_RD_LOAD
   } state_t;

   state_t                            state;
   logic                              aw_held;
   logic                              w_held;
   logic [axil_pkg::AXI_ADDR_W-1:0]   aw_addr;
   logic [axil_pkg::AXI_ADDR_W-1:0]   ar_addr;
   mmem_pkg::word_t                   w_data;
   logic [axil_pkg::STRB_W-1:0]       w_strb;
   logic                              accept;
   logic                              aw_take;
   logic                              w_take;
   logic                              ar_take;
   logic                              wr_ok;
   logic                              rd_ok;

   // New requests only when idle and both response registers are empty.
   assign accept  = (state == ST_IDLE) && !reset && b_in_ready && r_in_ready;
   assign awready = accept && !aw_held;
   assign wready  = accept && !w_held;
   // A write that is complete or about to be goes ahead of a read.
   assign arready = accept && !aw_held && !w_held && !(awvalid && wvalid);

   assign aw_take = awvalid && awready;
   assign w_take  = wvalid && wready;
   assign ar_take = arvalid && arready;

   assign wr_ok = (aw_addr <= axil_pkg::MAX_BYTE_ADDR) && (w_strb == '1);  // Full words only.
   assign rd_ok = (ar_addr <= axil_pkg::MAX_BYTE_ADDR);

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state   <= ST_IDLE;
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (aw_take)
                  aw_held <= 1'b1;
               if (w_take)
                  w_held <= 1'b1;
               if ((aw_held || aw_take) && (w_held || w_take))
                  state <= ST_WRITE;
               else if (ar_take)
                  state <= ST_RD_ISSUE;
            end
            ST_WRITE:
               if (b_in_ready)
               begin
                  aw_held <= 1'b0;
                  w_held  <= 1'b0;
                  state   <= ST_IDLE;
               end
            ST_RD_ISSUE:
               state <= ST_RD_LOAD;                // Data arrives on q next cycle.
            ST_RD_LOAD:
               if (r_in_ready)
                  state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (aw_take)
         aw_addr <= awaddr;
      if (w_take)
      begin
         w_data <= wdata;
         w_strb <= wstrb;
      end
      if (ar_take)
         ar_addr <= araddr;
   end

   assign mem.wren    = (state == ST_WRITE) && wr_ok && b_in_ready;
   assign mem.rden    = (state == ST_RD_ISSUE) && rd_ok;
   assign mem.address = (state == ST_WRITE) ? aw_addr[mmem_pkg::ADDR_W+1:2] :
                                              ar_addr[mmem_pkg::ADDR_W+1:2];
   assign mem.data    = w_data;

   assign b_valid = (state == ST_WRITE);
   assign r_valid = (state == ST_RD_LOAD);

   always_comb
   begin
      b_payload.resp = wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      r_payload.data = rd_ok ? mem.q : '0;        // Refused reads return zero.
      r_payload.resp = rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
   end

   // A response loaded on this edge is held next cycle, so no read address is taken then.
   a_no_ar_while_held: assert property (@(posedge clk_a) disable iff (reset)
      (b_valid || r_valid) |=> !arready);

endmodule

//--- design/part_32x32dpram.sv
// **********************************************************
// 32x32 dual-port synchronous RAM. Port A writes win over
// port B; each port has a registered read output.
// **********************************************************

`timescale 1ns/100ps

module part_32x32dpram
(
   input  logic       clk_a,
   input  logic       reset,
   mem_port_if.memory port_a,
   mem_port_if.memory port_b
);

   mmem_pkg::word_t ram [mmem_pkg::DEPTH];

   // Only one write per edge; a colliding port B write is dropped.
   always_ff @(posedge clk_a)
   begin
      if (port_a.wren)
         ram[port_a.address] <= port_a.data;
      else if (port_b.wren)
         ram[port_b.address] <= port_b.data;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         port_a.q <= '0;
      else if (port_a.rden)
         port_a.q <= ram[port_a.address];
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         port_b.q <= '0;
      else if (port_b.rden)
         port_b.q <= ram[port_b.address];
   end

   // Requesters never read and write one port in the same cycle.
   a_port_a_excl: assert property (@(posedge clk_a) disable iff (reset)
      !(port_a.wren && port_a.rden));

   a_port_b_excl: assert property (@(posedge clk_a) disable iff (reset)
      !(port_b.wren && port_b.rden));

endmodule

//--- design/resp_hold.sv
// **********************************************************
// One-entry valid/ready holding register for a response.
// **********************************************************

`timescale 1ns/100ps

module resp_hold
#(
   parameter type payload_t = logic
)
(
   input  logic     clk_a,
   input  logic     reset,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_payload,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_payload
);

   logic     full;
   payload_t entry;

   assign in_ready    = !full;
   assign out_valid   = full;
   assign out_payload = entry;

   always_ff @(posedge clk_a)
   begin
      if (reset)
         full <= 1'b0;
      else if (in_valid && !full)
         full <= 1'b1;
      else if (full && out_ready)
         full <= 1'b0;                            // Taken by the bus.
   end

   always_ff @(posedge clk_a)
   begin
      if (in_valid && !full)
         entry <= in_payload;
   end

   // Payload must not move while the bus is stalling it.
   a_payload_stable: assert property (@(posedge clk_a) disable iff (reset)
      (out_valid && !out_ready) |=> $stable(out_payload));

endmodule

//--- design/mmem_top.sv
// **********************************************************
// M-memory top: AXI4-Lite host port and microcode port on
// one shared 32x32 scratchpad.
// **********************************************************

`timescale 1ns/100ps

module mmem_top
(
   input  logic                              clk_a,
   input  logic                              reset,
   input  logic [axil_pkg::AXI_ADDR_W-1:0]   awaddr,
   input  logic                              awvalid,
   output logic                              awready,
   input  mmem_pkg::word_t                   wdata,
   input  logic [axil_pkg::STRB_W-1:0]       wstrb,
   input  logic                              wvalid,
   output logic                              wready,
   output axil_pkg::resp_t                   bresp,
   output logic                              bvalid,
   input  logic                              bready,
   input  logic [axil_pkg::AXI_ADDR_W-1:0]   araddr,
   input  logic                              arvalid,
   output logic                              arready,
   output mmem_pkg::word_t                   rdata,
   output axil_pkg::resp_t                   rresp,
   output logic                              rvalid,
   input  logic                              rready,
   input  mmem_pkg::addr_t                   m_addr,
   input  mmem_pkg::word_t                   m_wdata,
   input  logic                              m_wren,
   input  logic                              m_rden,
   output mmem_pkg::word_t                   m_rdata
);

   mem_port_if port_a_if ();
   mem_port_if port_b_if ();

   logic                 b_in_valid;
   logic                 b_in_ready;
   axil_pkg::b_payload_t b_in_payload;
   axil_pkg::b_payload_t b_out_payload;
   logic                 r_in_valid;
   logic                 r_in_ready;
   axil_pkg::r_payload_t r_in_payload;
   axil_pkg::r_payload_t r_out_payload;

   // Microcode datapath owns port B.
   assign port_b_if.address = m_addr;
   assign port_b_if.data    = m_wdata;
   assign port_b_if.wren    = m_wren;
   assign port_b_if.rden    = m_rden;
   assign m_rdata           = port_b_if.q;

   assign bresp = b_out_payload.resp;
   assign rdata = r_out_payload.data;
   assign rresp = r_out_payload.resp;

   axil_mmem_front i_front
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .b_valid    (b_in_valid),
      .b_payload  (b_in_payload),
      .b_in_ready (b_in_ready),
      .r_valid    (r_in_valid),
      .r_payload  (r_in_payload),
      .r_in_ready (r_in_ready),
      .mem        (port_a_if.requester)
   );

   part_32x32dpram i_ram
   (
      .clk_a  (clk_a),
      .reset  (reset),
      .port_a (port_a_if.memory),
      .port_b (port_b_if.memory)
   );

   resp_hold #(.payload_t(axil_pkg::b_payload_t)) i_b_hold
   (
      .clk_a       (clk_a),
      .reset       (reset),
      .in_valid    (b_in_valid),
      .in_ready    (b_in_ready),
      .in_payload  (b_in_payload),
      .out_valid   (bvalid),
      .out_ready   (bready),
      .out_payload (b_out_payload)
   );

   resp_hold #(.payload_t(axil_pkg::r_payload_t)) i_r_hold
   (
      .clk_a       (clk_a),
      .reset       (reset),
      .in_valid    (r_in_valid),
      .in_ready    (r_in_ready),
      .in_payload  (r_in_payload),
      .out_valid   (rvalid),
      .out_ready   (rready),
      .out_payload (r_out_payload)
   );

endmodule

//--- sim/tb_mmem_table.svh
// **********************************************************
// Stimulus and expected values for the M-memory testbench.
// **********************************************************

`ifndef TB_MMEM_TABLE_SVH
`define TB_MMEM_TABLE_SVH

localparam int N_ENTRIES = 21;

// Columns: op, addr (byte for host, word for microcode), data, strb,
// microcode addr, microcode data, expected data, expected resp.
entry_t table_q [N_ENTRIES] = '{
   '{OP_HWR,  8'h00, 32'h1111_0001, 4'hF, 5'd0, 32'h0, 32'h0,          2'b00},
   '{OP_HWR,  8'h04, 32'h2222_0002, 4'hF, 5'd0, 32'h0, 32'h0,          2'b00},
   '{OP_HWR,  8'h7C, 32'h7C7C_7C7C, 4'hF, 5'd0, 32'h0, 32'h0,          2'b00},
   '{OP_HRD,  8'h00, 32'h0,         4'hF, 5'd0, 32'h0, 32'h1111_0001, 2'b00},
   '{OP_HRD,  8'h04, 32'h0,         4'hF, 5'd0, 32'h0, 32'h2222_0002, 2'b00},
   '{OP_HRD,  8'h7C, 32'h0,         4'hF, 5'd0, 32'h0, 32'h7C7C_7C7C, 2'b00},
   '{OP_MWR,  8'h03, 32'hCAFE_0003, 4'hF, 5'd0, 32'h0, 32'h0,          2'b00},
   '{OP_HRD,  8'h0C, 32'h0,         4'hF, 5'd0, 32'h0, 32'hCAFE_0003, 2'b00},
   '{OP_HWR,  8'h10, 32'hBEEF_0004, 4'hF, 5'd0, 32'h0, 32'h0,          2'b00},
   '{OP_MRD,  8'h04, 32'h0,         4'hF, 5'd0, 32'h0, 32'hBEEF_0004, 2'b00},
   '{OP_BOTH, 8'h14, 32'h5555_0005, 4'hF, 5'd5, 32'hDEAD_0005, 32'h0,  2'b00},
   '{OP_HRD,  8'h14, 32'h0,         4'hF, 5'd0, 32'h0, 32'h5555_0005, 2'b00},
   '{OP_MWR,  8'h07, 32'h0BAD_0007, 4'hF, 5'd0, 32'h0, 32'h0,          2'b00},
   '{OP_BOTH, 8'h18, 32'h6666_0006, 4'hF, 5'd7, 32'h7777_0007, 32'h0,  2'b00},
   '{OP_MRD,  8'h07, 32'h0,         4'hF, 5'd0, 32'h0, 32'h0BAD_0007, 2'b00},
   '{OP_HWR,  8'h80, 32'hFFFF_FFFF, 4'hF, 5'd0, 32'h0, 32'h0,          2'b10},
   '{OP_HWR,  8'h00, 32'h9999_9999, 4'h3, 5'd0, 32'h0, 32'h0,          2'b10},
   '{OP_HRD,  8'h00, 32'h0,         4'hF, 5'd0, 32'h0, 32'h1111_0001, 2'b00},
   '{OP_HRD,  8'h80, 32'h0,         4'hF, 5'd0, 32'h0, 32'h0,          2'b10},
   '{OP_HRD,  8'hFC, 32'h0,         4'hF, 5'd0, 32'h0, 32'h0,          2'b10},
   '{OP_MRD,  8'h00, 32'h0,         4'hF, 5'd0, 32'h0, 32'h1111_0001, 2'b00}
};

`endif

//--- sim/tb_mmem_top.sv
// **********************************************************
// Testbench for the M-memory: table-driven host and microcode
// accesses checked against a reference word array.
// **********************************************************

`timescale 1ns/100ps

module tb_mmem_top;

   localparam int OP_HWR  = 0;
   localparam int OP_HRD  = 1;
   localparam int OP_MWR  = 2;
   localparam int OP_MRD  = 3;
   localparam int OP_BOTH = 4;

   typedef struct {
      int          op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [3:0]  strb;
      logic [4:0]  m_addr;
      logic [31:0] m_data;
      logic [31:0] exp_data;
      logic [1:0]  exp_resp;
   } entry_t;

   `include "tb_mmem_table.svh"

   logic clk_a, reset;
   logic [7:0] awaddr, araddr;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready, m_wren, m_rden;
   logic [31:0] wdata, rdata, m_wdata, m_rdata;
   logic [3:0] wstrb;
   logic [1:0] bresp, rresp;
   logic [4:0] m_addr;

   logic [31:0] model [32];                      // Reference copy of the scratchpad.
   int entry_err, pass_count, fail_count;

   mmem_top i_mmem_top (.*);

   initial
   begin
      clk_a = 1'b0;
      forever
         #20 clk_a = ~clk_a;
   end

   initial
   begin
      #((N_ENTRIES * 30 + 8) * 40);
      $display("Watchdog expired before all table entries completed.");
      $display("Done: errors found");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp, act);
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
      entry_err++;
   endtask

   // Holds the response for a random 0..3 cycles, then takes it.
   task automatic hold_b(input logic [1:0] resp);
      int d;
      d = $urandom % 4;
      repeat (d)
      begin
         @(posedge clk_a);
         if (bvalid !== 1'b1) report_mismatch("bvalid", 1, bvalid);
         if (bresp !== resp) report_mismatch("bresp", resp, bresp);
         if (awready || wready || arready)
         begin
            $display("Address accepted at %0t ns while a write response was held.", $time);
            entry_err++;
         end
      end
      bready <= 1'b1;
      @(posedge clk_a);
      bready <= 1'b0;
   endtask

   task automatic hold_r(input logic [31:0] data, input logic [1:0] resp);
      int d;
      d = $urandom % 4;
      repeat (d)
      begin
         @(posedge clk_a);
         if (rvalid !== 1'b1) report_mismatch("rvalid", 1, rvalid);
         if (rdata !== data) report_mismatch("rdata", data, rdata);
         if (rresp !== resp) report_mismatch("rresp", resp, rresp);
         if (awready || wready || arready)
         begin
            $display("Address accepted at %0t ns while a read response was held.", $time);
            entry_err++;
         end
      end
      rready <= 1'b1;
      @(posedge clk_a);
      rready <= 1'b0;
   endtask

   task automatic host_write(input entry_t e, input bit with_m);
      int cyc;
      int n;
      bit aw_done;
      bit w_done;
      bit ok;
      ok = (e.addr <= 8'h7C) && (e.strb == 4'hF);
      awaddr <= e.addr;
      awvalid <= 1'b1;
      wdata <= e.data;
      wstrb <= e.strb;
      wvalid <= 1'b1;
      cyc = 0;
      aw_done = 0;
      w_done = 0;
      while (!(aw_done && w_done) && cyc < 20)
      begin
         @(posedge clk_a);
         cyc++;
         if (awvalid && awready)
         begin
            aw_done = 1;
            awvalid <= 1'b0;
         end
         if (wvalid && wready)
         begin
            w_done = 1;
            wvalid <= 1'b0;
         end
      end
      if (!(aw_done && w_done))
      begin
         $display("Write address or data handshake never completed.");
         entry_err++;
         return;
      end
      if (with_m)
      begin
         m_addr <= e.m_addr;
         m_wdata <= e.m_data;
         m_wren <= 1'b1;                           // Same edge as port A.
      end
      n = 0;
      do
      begin
         @(posedge clk_a);
         n++;
         if (with_m && n == 1) m_wren <= 1'b0;
      end while (!bvalid && n < 20);
      if (!bvalid)
      begin
         $display("Write response never arrived.");
         entry_err++;
         return;
      end
      if (n != 2) report_mismatch("bvalid delay", 2, n);
      if (bresp !== e.exp_resp) report_mismatch("bresp", e.exp_resp, bresp);
      if (ok)
         model[e.addr[6:2]] = e.data;
      else if (with_m)
         model[e.m_addr] = e.m_data;
      hold_b(e.exp_resp);
   endtask

   task automatic host_read(input entry_t e);
      int cyc;
      int n;
      bit ar_done;
      logic [31:0] exp;
      exp = (e.addr <= 8'h7C) ? model[e.addr[6:2]] : 32'h0;
      if (exp !== e.exp_data)
      begin
         $display("Reference model and table disagree on the read data.");
         entry_err++;
      end
      araddr <= e.addr;
      arvalid <= 1'b1;
      cyc = 0;
      ar_done = 0;
      while (!ar_done && cyc < 20)
      begin
         @(posedge clk_a);
         cyc++;
         if (arvalid && arready)
            ar_done = 1;
      end
      arvalid <= 1'b0;
      if (!ar_done)
      begin
         $display("Read address handshake never completed.");
         entry_err++;
         return;
      end
      n = 0;
      do
      begin
         @(posedge clk_a);
         n++;
      end while (!rvalid && n < 20);
      if (!rvalid)
      begin
         $display("Read response never arrived.");
         entry_err++;
         return;
      end
      if (n != 3) report_mismatch("rvalid delay", 3, n);
      if (rdata !== exp) report_mismatch("rdata", exp, rdata);
      if (rresp !== e.exp_resp) report_mismatch("rresp", e.exp_resp, rresp);
      hold_r(exp, e.exp_resp);
   endtask

   task automatic micro_access(input entry_t e);
      m_addr <= e.addr[4:0];
      if (e.op == OP_MWR)
      begin
         m_wdata <= e.data;
         m_wren <= 1'b1;
         @(posedge clk_a);
         m_wren <= 1'b0;
         model[e.addr[4:0]] = e.data;
      end
      else
      begin
         m_rden <= 1'b1;
         @(posedge clk_a);
         m_rden <= 1'b0;
         @(posedge clk_a);
         if (m_rdata !== model[e.addr[4:0]])
            report_mismatch("m_rdata", model[e.addr[4:0]], m_rdata);
         if (m_rdata !== e.exp_data) report_mismatch("m_rdata", e.exp_data, m_rdata);
      end
   endtask

   initial
   begin
      void'($urandom(32'h3adc_a57a));
      pass_count = 0;
      fail_count = 0;
      reset <= 1'b1;
      awaddr <= '0;
      awvalid <= 1'b0;
      wdata <= '0;
      wstrb <= '0;
      wvalid <= 1'b0;
      bready <= 1'b0;
      araddr <= '0;
      arvalid <= 1'b0;
      rready <= 1'b0;
      m_addr <= '0;
      m_wdata <= '0;
      m_wren <= 1'b0;
      m_rden <= 1'b0;
      repeat (8) @(posedge clk_a);
      reset <= 1'b0;
      @(posedge clk_a);                           // Samples the first cycle after reset.
      entry_err = 0;
      if (bvalid !== 1'b0) report_mismatch("bvalid", 0, bvalid);
      if (rvalid !== 1'b0) report_mismatch("rvalid", 0, rvalid);
      if (m_rdata !== 32'h0) report_mismatch("m_rdata", 0, m_rdata);
      if (awready !== 1'b1) report_mismatch("awready", 1, awready);
      if (wready !== 1'b1) report_mismatch("wready", 1, wready);
      if (arready !== 1'b1) report_mismatch("arready", 1, arready);
      if (entry_err == 0) pass_count++;
      else fail_count++;
      $display("reset check: %s", (entry_err == 0) ? "passed" : "failed");
      for (int i = 0; i < N_ENTRIES; i++)
      begin
         entry_err = 0;
         case (table_q[i].op)
            OP_HWR:  host_write(table_q[i], 1'b0);
            OP_BOTH: host_write(table_q[i], 1'b1);
            OP_HRD:  host_read(table_q[i]);
            default: micro_access(table_q[i]);
         endcase
         if (entry_err == 0) pass_count++;
         else fail_count++;
         $display("entry %0d op %0d: %s", i, table_q[i].op,
                  (entry_err == 0) ? "passed" : "failed");
      end
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

//--- files.f
+incdir+sim
design/mmem_pkg.sv
design/axil_pkg.sv
design/mem_port_if.sv
design/axil_mmem_front.sv
design/part_32x32dpram.sv
design/resp_hold.sv
design/mmem_top.sv
sim/tb_mmem_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_mmem_top
FILELIST  = files.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
